/* src/fetchPkg.sv */
package fetchPkg;

    // Data and address width of the processor
    localparam int XLEN = 32;

    // The opcode field sits in the top five bits of every instruction
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int OPCODE_W = OPCODE_MSB - OPCODE_LSB + 1;

    // Opcode families of the ISA
    // Fetch itself only looks for OP_HALT, the rest name the other instruction classes
    typedef enum logic [OPCODE_W-1:0] {
        OP_HALT   = 5'd0,
        OP_NOP    = 5'd1,
        OP_ALU    = 5'd2,
        OP_LOAD   = 5'd3,
        OP_STORE  = 5'd4,
        OP_BRANCH = 5'd5,
        OP_JUMP   = 5'd6
    } opcodeE;

    // Bubble word placed into IF/ID on a flush and after reset
    // Opcode is OP_NOP and every other field is zero
    localparam logic [XLEN-1:0] NOP_INSTR = {OP_NOP, {OPCODE_LSB{1'b0}}};

    // Program counter value after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

endpackage

/* src/ifIdIf.sv */
interface ifIdIf;

    // High whenever the fetch stage presents a real instruction
    logic valid;

    // Instruction word read from the instruction memory this cycle
    logic [fetchPkg::XLEN-1:0] instr;

    // Address of the sequential successor of the fetched instruction
    logic [fetchPkg::XLEN-1:0] plus4PC;

    // Decode reports that the slot being captured is on the wrong path
    logic flush;

    // Fetch side drives the slot contents
    modport fetch (
        output valid,
        output instr,
        output plus4PC
    );

    // The IF/ID register receives the slot and the flush request
    modport ifId (
        input valid,
        input instr,
        input plus4PC,
        input flush
    );

endinterface

/* src/claAdder32.sv */
module claAdder32 (
    input  logic [fetchPkg::XLEN-1:0] a,
    input  logic [fetchPkg::XLEN-1:0] b,
    output logic [fetchPkg::XLEN-1:0] sum
);

    localparam int GROUPS = fetchPkg::XLEN / 4;

    // Per-bit propagate and generate
    logic [fetchPkg::XLEN-1:0] bitProp;
    logic [fetchPkg::XLEN-1:0] bitGen;
    logic [fetchPkg::XLEN-1:0] bitCarry;

    // Per-group terms and the carry into each group
    logic [GROUPS-1:0] groupProp;
    logic [GROUPS-1:0] groupGen;
    logic [GROUPS-1:0] groupCarry;

    assign bitProp = a ^ b;
    assign bitGen = a & b;

    for (genvar k = 0; k < GROUPS; k++) begin : gGroup
        localparam int LSB = 4 * k;
        logic [3:0] p;
        logic [3:0] g;
        logic cIn;

        assign p = bitProp[LSB+3:LSB];
        assign g = bitGen[LSB+3:LSB];
        assign cIn = groupCarry[k];

        // Carries inside the group, each one expanded from the group carry-in
        assign bitCarry[LSB] = cIn;
        assign bitCarry[LSB+1] = g[0] | (p[0] & cIn);
        assign bitCarry[LSB+2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cIn);
        assign bitCarry[LSB+3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                               | (p[2] & p[1] & p[0] & cIn);

        // Group terms feed the second lookahead level
        assign groupProp[k] = &p;
        assign groupGen[k] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                           | (p[3] & p[2] & p[1] & g[0]);
    end

    // Second level: every group carry is a sum of products over the lower groups
    // The adder has no carry-in, so group zero starts from a zero carry
    always_comb begin
        logic spanProp;
        groupCarry[0] = 1'b0;
        for (int k = 1; k < GROUPS; k++) begin
            spanProp = 1'b1;
            groupCarry[k] = 1'b0;
            // Walk down from the nearest group, accumulating the propagate chain
            for (int j = k - 1; j >= 0; j--) begin
                groupCarry[k] = groupCarry[k] | (spanProp & groupGen[j]);
                spanProp = spanProp & groupProp[j];
            end
        end
    end

    assign sum = bitProp ^ bitCarry;

endmodule

/* src/programCounter.sv */
module programCounter (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      hold,
    input  logic [fetchPkg::XLEN-1:0] nextAddr,
    output logic [fetchPkg::XLEN-1:0] currAddr
);

    // The PC register
    // Reset puts fetch back at the reset vector
    // While hold is high the current address is kept, so the same word is fetched again
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            currAddr <= fetchPkg::RESET_PC;
        end else if (!hold) begin
            currAddr <= nextAddr;
        end
    end

endmodule

/* src/instrMem.sv */
module instrMem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                      clk,
    input  logic                      loadEn,
    input  logic [fetchPkg::XLEN-1:0] loadAddr,
    input  logic [fetchPkg::XLEN-1:0] loadData,
    input  logic [fetchPkg::XLEN-1:0] addr,
    output logic [fetchPkg::XLEN-1:0] data
);

    // Number of word index bits, the depth is a power of two
    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [fetchPkg::XLEN-1:0] mem [IMEM_DEPTH];

    logic [IDX_W-1:0] readIdx;
    logic [IDX_W-1:0] writeIdx;

    // Byte addresses become word indices by dropping the two offset bits
    // Upper address bits are ignored, so the array wraps modulo its depth
    assign readIdx = addr[IDX_W+1:2];
    assign writeIdx = loadAddr[IDX_W+1:2];

    // Load port
    // One word per rising edge while the strobe is high, nothing acknowledges it
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[writeIdx] <= loadData;
        end
    end

    // Read port is combinational
    // A read of the word being loaded still returns the old contents until the edge
    assign data = mem[readIdx];

endmodule

/* src/fetchStage.sv */
module fetchStage (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [fetchPkg::XLEN-1:0] nextPC,
    input  logic                      srcPC,
    input  logic                      branchStallExe,
    input  logic                      branchStallDec,
    input  logic                      stallPC,
    input  logic                      haltDec,
    input  logic                      haltExe,
    input  logic                      haltMem,
    input  logic                      haltWb,
    output logic [fetchPkg::XLEN-1:0] imemAddr,
    input  logic [fetchPkg::XLEN-1:0] imemData,
    output logic                      halt,
    ifIdIf.fetch                      slot
);

    // Instructions are one word apart
    localparam logic [fetchPkg::XLEN-1:0] INSTR_BYTES = fetchPkg::XLEN'(4);

    logic                      redirect;
    logic                      pcHold;
    logic [fetchPkg::XLEN-1:0] currPC;
    logic [fetchPkg::XLEN-1:0] seqPlus4;
    logic [fetchPkg::XLEN-1:0] targetPlus4;
    logic [fetchPkg::XLEN-1:0] plus4Sel;
    fetchPkg::opcodeE          fetchOpcode;

    // Execute redirects fetch only when it marks the redirect cycle and selects nextPC
    assign redirect = branchStallExe & srcPC;

    // A hazard stall or a halt in decode freezes the PC
    assign pcHold = stallPC | haltDec;

    programCounter iPc (
        .clk      (clk),
        .arstN    (arstN),
        .hold     (pcHold),
        .nextAddr (plus4Sel),
        .currAddr (currPC)
    );

    // Sequential successor of the current PC
    claAdder32 iPcAdder (
        .a   (currPC),
        .b   (INSTR_BYTES),
        .sum (seqPlus4)
    );

    // Successor of the branch target, so fetch continues past it next cycle
    claAdder32 iBranchAdder (
        .a   (nextPC),
        .b   (INSTR_BYTES),
        .sum (targetPlus4)
    );

    // On a redirect the target is read straight away instead of waiting a cycle for the PC
    assign imemAddr = redirect ? nextPC : currPC;
    assign plus4Sel = redirect ? targetPlus4 : seqPlus4;

    assign fetchOpcode = fetchPkg::opcodeE'(imemData[fetchPkg::OPCODE_MSB:fetchPkg::OPCODE_LSB]);

    // A fetched halt counts only if decode does not discard this slot as wrong-path
    // Halts coming back from later stages always stop fetch
    assign halt = ((fetchOpcode == fetchPkg::OP_HALT) && !branchStallDec)
                | haltDec | haltExe | haltMem | haltWb;

    // Every cycle presents a slot, the IF/ID register decides whether to take it
    assign slot.valid = 1'b1;
    assign slot.instr = imemData;
    assign slot.plus4PC = plus4Sel;

endmodule

/* src/ifIdReg.sv */
module ifIdReg (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      stallPC,
    ifIdIf.ifId                       slot,
    output logic                      decValid,
    output logic [fetchPkg::XLEN-1:0] decInstr,
    output logic [fetchPkg::XLEN-1:0] decPlus4PC
);

    // The IF/ID pipeline register
    // After reset decode sees a bubble with a zero successor address
    // A flush has priority over a stall, so a wrong-path slot is dropped even while stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
            decInstr <= fetchPkg::NOP_INSTR;
            decPlus4PC <= '0;
        end else if (slot.flush) begin
            // Bubble looks exactly like the reset state
            decValid <= 1'b0;
            decInstr <= fetchPkg::NOP_INSTR;
            decPlus4PC <= '0;
        end else if (!stallPC) begin
            decValid <= slot.valid;
            decInstr <= slot.instr;
            decPlus4PC <= slot.plus4PC;
        end
    end

endmodule

/* src/fetchUnit.sv */
module fetchUnit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [fetchPkg::XLEN-1:0] nextPC,
    input  logic                      srcPC,
    input  logic                      branchStallExe,
    input  logic                      stallPC,
    input  logic                      branchStallDec,
    input  logic                      haltDec,
    input  logic                      haltExe,
    input  logic                      haltMem,
    input  logic                      haltWb,
    input  logic                      loadEn,
    input  logic [fetchPkg::XLEN-1:0] loadAddr,
    input  logic [fetchPkg::XLEN-1:0] loadData,
    output logic                      halt,
    output logic                      decValid,
    output logic [fetchPkg::XLEN-1:0] decInstr,
    output logic [fetchPkg::XLEN-1:0] decPlus4PC
);

    // Read path between the fetch stage and the memory
    logic [fetchPkg::XLEN-1:0] imemAddr;
    logic [fetchPkg::XLEN-1:0] imemData;

    // Fetched slot on its way into IF/ID
    ifIdIf slotBus ();

    // A wrong-path report from decode turns the captured slot into a bubble
    assign slotBus.flush = branchStallDec;

    fetchStage iFetch (
        .clk            (clk),
        .arstN          (arstN),
        .nextPC         (nextPC),
        .srcPC          (srcPC),
        .branchStallExe (branchStallExe),
        .branchStallDec (branchStallDec),
        .stallPC        (stallPC),
        .haltDec        (haltDec),
        .haltExe        (haltExe),
        .haltMem        (haltMem),
        .haltWb         (haltWb),
        .imemAddr       (imemAddr),
        .imemData       (imemData),
        .halt           (halt),
        .slot           (slotBus.fetch)
    );

    instrMem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) iImem (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .addr     (imemAddr),
        .data     (imemData)
    );

    ifIdReg iIfId (
        .clk        (clk),
        .arstN      (arstN),
        .stallPC    (stallPC),
        .slot       (slotBus.ifId),
        .decValid   (decValid),
        .decInstr   (decInstr),
        .decPlus4PC (decPlus4PC)
    );

endmodule

/* dv/clkGen.sv */
module clkGen (
    input  logic forceRst,
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    // Low until the power-on reset has lasted three full clock cycles
    logic porDone;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release happens on a falling edge, away from the rising edge the DUT uses
    initial begin
        porDone = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        porDone = 1'b1;
    end

    // The testbench can pull reset low again at any time
    assign arstN = porDone & ~forceRst;

endmodule

/* dv/fetchUnitTb.sv */
module fetchUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 256;
    // Bubble word has opcode one in the top five bits and zero elsewhere
    localparam logic [31:0] BUBBLE = 32'h0800_0000;
    localparam int WAIT_LIMIT = 20;
    localparam int MODE_LOAD = 0;
    localparam int MODE_SEQ = 1;
    localparam int MODE_MIXED = 2;

    logic        clk;
    logic        arstN;
    logic        forceRst;
    logic [31:0] nextPC;
    logic        srcPC;
    logic        branchStallExe;
    logic        stallPC;
    logic        branchStallDec;
    logic        haltDec;
    logic        haltExe;
    logic        haltMem;
    logic        haltWb;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic        halt;
    logic        decValid;
    logic [31:0] decInstr;
    logic [31:0] decPlus4PC;

    integer seed = 77975;
    int     errors = 0;
    int     checks = 0;
    int     stallLeft = 0;
    logic   haltCheckOn;

    // Reference state holds the memory image, the PC and the IF/ID register
    logic [31:0] modelMem [DEPTH];
    logic [31:0] modelPc;
    logic        modelValid;
    logic [31:0] modelInstr;
    logic [31:0] modelPlus4;

    clkGen iClk (
        .forceRst (forceRst),
        .clk      (clk),
        .arstN    (arstN)
    );

    fetchUnit #(
        .IMEM_DEPTH (DEPTH)
    ) i_dut (
        .clk (clk), .arstN (arstN), .nextPC (nextPC), .srcPC (srcPC),
        .branchStallExe (branchStallExe), .stallPC (stallPC),
        .branchStallDec (branchStallDec), .haltDec (haltDec), .haltExe (haltExe),
        .haltMem (haltMem), .haltWb (haltWb), .loadEn (loadEn), .loadAddr (loadAddr),
        .loadData (loadData), .halt (halt), .decValid (decValid), .decInstr (decInstr),
        .decPlus4PC (decPlus4PC)
    );

    function automatic logic chance(input int n);
        return ({$random(seed)} % n) == 0;
    endfunction

    // Random instruction where halt opcodes appear only when allowed
    function automatic logic [31:0] randomInstr(input logic allowHalt);
        fetchPkg::opcodeE op;
        op = fetchPkg::opcodeE'(5'(1 + ({$random(seed)} % 6)));
        if (allowHalt && chance(4)) begin
            op = fetchPkg::OP_HALT;
        end
        return {op, 27'($random(seed))};
    endfunction

    // Byte address to word index wrapping modulo the memory depth
    function automatic int wordIdx(input logic [31:0] addr);
        return int'((addr >> 2) % DEPTH);
    endfunction

    function automatic logic [31:0] fetchAddr();
        return (branchStallExe && srcPC) ? nextPC : modelPc;
    endfunction

    function automatic logic expectHalt();
        logic [31:0] word;
        word = modelMem[wordIdx(fetchAddr())];
        return ((word[31:27] == fetchPkg::OP_HALT) && !branchStallDec)
            || haltDec || haltExe || haltMem || haltWb;
    endfunction

    task automatic resetModel();
        modelPc = 32'h0;
        modelValid = 1'b0;
        modelInstr = BUBBLE;
        modelPlus4 = 32'h0;
    endtask

    // What the next rising edge does to the DUT
    task automatic advanceModel();
        logic [31:0] addr;
        logic [31:0] word;
        addr = fetchAddr();
        word = modelMem[wordIdx(addr)];
        if (!arstN) begin
            resetModel();
        end else begin
            // Flush beats stall
            if (branchStallDec) begin
                modelValid = 1'b0;
                modelInstr = BUBBLE;
                modelPlus4 = 32'h0;
            end else if (!stallPC) begin
                modelValid = 1'b1;
                modelInstr = word;
                modelPlus4 = addr + 32'd4;
            end
            if (!(stallPC || haltDec)) begin
                modelPc = addr + 32'd4;
            end
        end
        // The write lands after the read of the same edge
        if (loadEn) begin
            modelMem[wordIdx(loadAddr)] = loadData;
        end
    endtask

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("Error at time %0d: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic checkRegs();
        checks += 3;
        if (decValid !== modelValid) mismatch("decValid", 32'(decValid), 32'(modelValid));
        if (decInstr !== modelInstr) mismatch("decInstr", decInstr, modelInstr);
        if (decPlus4PC !== modelPlus4) mismatch("decPlus4PC", decPlus4PC, modelPlus4);
    endtask

    task automatic clearInputs();
        nextPC = 32'h0;
        srcPC = 1'b0;
        branchStallExe = 1'b0;
        stallPC = 1'b0;
        branchStallDec = 1'b0;
        haltDec = 1'b0;
        haltExe = 1'b0;
        haltMem = 1'b0;
        haltWb = 1'b0;
        loadEn = 1'b0;
        loadAddr = 32'h0;
        loadData = 32'h0;
    endtask

    task automatic pickInputs(input int mode, input int idx);
        clearInputs();
        if (mode == MODE_LOAD) begin
            // Stall keeps fetch parked at zero while the image goes in
            stallPC = 1'b1;
            loadEn = 1'b1;
            loadAddr = 32'(idx * 4);
            loadData = randomInstr(1'b0);
        end else if (mode == MODE_MIXED) begin
            if (chance(6)) begin
                branchStallExe = 1'b1;
                srcPC = 1'b1;
                nextPC = {$random(seed)} & ~32'h3;
            end else if (chance(8)) begin
                // Only half of the redirect condition is raised so fetch goes on in order
                if (chance(2)) branchStallExe = 1'b1;
                else srcPC = 1'b1;
                nextPC = {$random(seed)} & ~32'h3;
            end
            if (stallLeft == 0 && chance(10)) begin
                stallLeft = 1 + int'({$random(seed)} % 5);
            end
            if (stallLeft > 0) begin
                stallPC = 1'b1;
                stallLeft--;
            end
            branchStallDec = chance(8);
            haltDec = chance(16);
            haltExe = chance(16);
            haltMem = chance(16);
            haltWb = chance(16);
            // Occasional loads scatter halt words through memory
            if (chance(8)) begin
                loadEn = 1'b1;
                loadAddr = {$random(seed)} & ~32'h3;
                loadData = randomInstr(1'b1);
            end
        end
    endtask

    // Each cycle drives on the falling edge, checks halt and predicts the edge
    // The registered outputs are sampled 1 ns before the next falling edge
    task automatic runCycle(input int mode, input int idx, input logic rst);
        @(negedge clk);
        forceRst = rst;
        pickInputs(mode, idx);
        #1;
        if (!arstN) begin
            resetModel();
            checkRegs();
        end
        if (haltCheckOn) begin
            checks++;
            if (halt !== expectHalt()) mismatch("halt", 32'(halt), 32'(expectHalt()));
        end
        advanceModel();
        @(posedge clk);
        #3;
        checkRegs();
    endtask

    task automatic waitResetRelease(output logic released);
        int n;
        n = 0;
        while (arstN !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        released = (arstN === 1'b1);
    endtask

    task automatic runPhases();
        checkRegs();
        for (int i = 0; i < DEPTH; i++) begin
            runCycle(MODE_LOAD, i, 1'b0);
        end
        haltCheckOn = 1'b1;
        repeat (300) runCycle(MODE_SEQ, 0, 1'b0);
        repeat (2000) runCycle(MODE_MIXED, 0, 1'b0);
        // Reset in the middle of the run makes fetch start over from zero
        repeat (3) runCycle(MODE_SEQ, 0, 1'b1);
        repeat (60) runCycle(MODE_SEQ, 0, 1'b0);
        repeat (500) runCycle(MODE_MIXED, 0, 1'b0);
    endtask

    initial begin
        logic released;
        forceRst = 1'b0;
        haltCheckOn = 1'b0;
        clearInputs();
        // Fetch stays parked at the reset vector until the memory image is loaded
        stallPC = 1'b1;
        resetModel();
        waitResetRelease(released);
        if (!released) begin
            $display("Timeout: reset was still asserted after %0d cycles", WAIT_LIMIT);
            $display("Errors found");
        end else begin
            runPhases();
            $display("Run complete: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

/* fetchUnit.f */
src/fetchPkg.sv
src/ifIdIf.sv
src/claAdder32.sv
src/programCounter.sv
src/instrMem.sv
src/fetchStage.sv
src/ifIdReg.sv
src/fetchUnit.sv
dv/clkGen.sv
dv/fetchUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the fetch unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f fetchUnit.f --top-module fetchUnitTb \
    -Mdir "$BUILD_DIR" -o fetchUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fetchUnitSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its fail line whenever a check fails or a wait times out
if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
